// ==== video_timing_top.f ====
+incdir+src
src/video_format_pkg.sv
src/raster_pkg.sv
src/format_select.sv
src/timing_table.sv
src/raster_counter.sv
src/sync_align.sv
src/video_timing_top.sv
sim/tb_video_timing.sv

// ==== Bender.yml ====
package:
  name: video_timing

export_include_dirs:
  - src

sources:
  - src/video_format_pkg.sv
  - src/raster_pkg.sv
  - src/format_select.sv
  - src/timing_table.sv
  - src/raster_counter.sv
  - src/sync_align.sv
  - src/video_timing_top.sv
  - target: test
    files:
      - sim/tb_video_timing.sv

// ==== sim/tb_video_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_defs.svh"

module tb_video_timing;
	import raster_pkg::*;

	// Expected figures of one format
	typedef struct packed {
		int   line_len;    // Clocks per line
		int   hs_width;    // Hsync clocks
		int   h_live;      // De clocks per line
		int   frame_lines;
		int   vs_width;    // Vsync lines
		int   v_live;      // Lines holding de
		logic neg;         // Active low syncs
	} ref_timing_t;

	localparam int CLK_HALF = 10;
	localparam int SETTLE   = 20;  // Switch edge to restarted outputs is 8
	localparam int N_TESTS  = 6;

	logic                pclk;
	logic                RSTBTN;
	logic [`VT_SW_W-1:0] sw;
	video_sync_t         video_out;
	raster_pos_t         pos;

	// Each code differs in format from the one before, so each change restarts
	logic [`VT_SW_W-1:0] test_codes [N_TESTS] =
		'{4'b0001, 4'b0011, 4'b0010, 4'b1000, 4'b0111, 4'b1001};
	string test_names [N_TESTS] =
		'{"svga", "xga", "hd720", "sxga", "unlisted_0111", "camera"};

	int                  errors = 0;
	int                  checks = 0;
	string               test_name;
	logic [`VT_SW_W-1:0] cur_code;
	int                  m_line_len, m_hs_width, m_h_live;      // Last measured line
	int                  m_frame_lines, m_vs_width, m_v_live;   // Last measured frame
	logic                m_neg;
	logic                m_is_frame;
	event                meas_ready;
	event                cmp_done;

	video_timing_top uut (
		.pclk     (pclk),
		.RSTBTN   (RSTBTN),
		.sw       (sw),
		.video_out(video_out),
		.pos      (pos)
	);

	initial begin
		pclk = 1'b0;
		forever #CLK_HALF pclk = ~pclk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference timing
	////////////////////////////////////////////////////////////////////////////

	function automatic ref_timing_t from_porches(input int h_live, h_fp, h_pw, h_bp,
	                                             input int v_live, v_fp, v_pw, v_bp,
	                                             input logic neg);
		ref_timing_t r;
		r.line_len    = h_live + h_fp + h_pw + h_bp;
		r.hs_width    = h_pw;
		r.h_live      = h_live;
		r.frame_lines = v_live + v_fp + v_pw + v_bp;
		r.vs_width    = v_pw;
		r.v_live      = v_live;
		r.neg         = neg;
		return r;
	endfunction

	function automatic ref_timing_t ref_timing(input logic [`VT_SW_W-1:0] code);
		case (code)
			4'b0000: return from_porches(640, 16, 96, 48, 480, 10, 2, 33, 1'b1);      // VGA
			4'b0001: return from_porches(800, 40, 128, 88, 600, 1, 4, 23, 1'b0);      // SVGA
			4'b0011: return from_porches(1024, 24, 136, 160, 768, 3, 6, 29, 1'b1);    // XGA
			4'b1000: return from_porches(1280, 48, 112, 248, 1024, 1, 3, 38, 1'b0);   // SXGA
			4'b1001: return from_porches(1280, 110, 39, 220, 720, 4, 4, 22, 1'b0);    // Camera
			default: return from_porches(1280, 110, 40, 220, 720, 5, 5, 20, 1'b0);    // 720p
		endcase
	endfunction

	// VGA frame, then 4 lines and settle per format, with 50% margin
	function automatic longint run_limit();
		longint      total;
		ref_timing_t r;
		r = ref_timing(4'b0000);
		total = longint'(r.line_len) * r.frame_lines + 2;
		for (int k = 0; k < N_TESTS; k++) begin
			r = ref_timing(test_codes[k]);
			total += 4 * r.line_len + SETTLE;
		end
		return total * 3 / 2;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input int want, input int got);
		checks++;
		assert (got == want)
		else begin
			errors++;
			$display("mismatch %s expected %0d actual %0d", name, want, got);
		end
	endtask

	task automatic check_true(input logic ok, input string what);
		checks++;
		assert (ok)
		else begin
			errors++;
			$display("%s", what);
		end
	endtask

	// Comparing process woken once per measurement
	always begin : compare
		ref_timing_t want;
		@(meas_ready);
		want = ref_timing(cur_code);
		if (m_is_frame) begin
			check_value({test_name, " frame_lines"}, want.frame_lines, m_frame_lines);
			check_value({test_name, " vsync_lines"}, want.vs_width, m_vs_width);
			check_value({test_name, " live_lines"}, want.v_live, m_v_live);
		end else begin
			check_value({test_name, " line_len"}, want.line_len, m_line_len);
			check_value({test_name, " hsync_width"}, want.hs_width, m_hs_width);
			check_value({test_name, " live_pixels"}, want.h_live, m_h_live);
		end
		check_value({test_name, " neg_sync"}, int'(want.neg), int'(m_neg));
		-> cmp_done;
	end

	task automatic compare_now();
		-> meas_ready;
		@(cmp_done);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Measuring at the outputs on the falling edge
	////////////////////////////////////////////////////////////////////////////

	// One frame of video_out, starting with pos at the origin
	task automatic measure_frame();
		int   tail;
		logic hs_idle, vs_idle, hs_prev, de_prev;
		check_true(pos.hcount == 0 && pos.vcount == 0,
		           "raster not at the origin after reset");
		repeat (2) @(negedge pclk);      // video_out trails pos by two
		hs_idle = video_out.hsync;       // Origin is live with both syncs idle
		vs_idle = video_out.vsync;
		hs_prev = video_out.hsync;
		de_prev = video_out.de;
		m_frame_lines = 0;
		m_vs_width    = 0;
		m_v_live      = 0;
		tail          = -1;
		while (tail != 0) begin
			@(negedge pclk);
			if (video_out.hsync != hs_idle && hs_prev == hs_idle) begin
				m_frame_lines++;           // One hsync start per line
				if (video_out.vsync != vs_idle)
					m_vs_width++;
			end
			if (video_out.de && !de_prev)
				m_v_live++;
			hs_prev = video_out.hsync;
			de_prev = video_out.de;
			if (tail > 0)
				tail--;
			else if (pos.hcount == 0 && pos.vcount == 0)
				tail = 2;                  // Two more to close the frame at video_out
		end
		m_neg      = vs_idle;
		m_is_frame = 1'b1;
	endtask

	// One full line from a de rise to the next
	task automatic measure_line();
		logic de_prev, hs_idle, rise;
		rise    = 1'b0;
		de_prev = video_out.de;
		while (!rise) begin
			@(negedge pclk);
			rise    = video_out.de && !de_prev;
			de_prev = video_out.de;
		end
		hs_idle    = video_out.hsync;
		m_line_len = 1;
		m_h_live   = 1;
		m_hs_width = 0;
		rise       = 1'b0;
		while (!rise) begin
			@(negedge pclk);
			rise    = video_out.de && !de_prev;
			de_prev = video_out.de;
			if (!rise) begin
				m_line_len++;
				m_h_live   += video_out.de;
				m_hs_width += (video_out.hsync != hs_idle);
			end
		end
		m_neg      = hs_idle;
		m_is_frame = 1'b0;
	endtask

	// New switch code and watch for pos at the origin
	task automatic change_format(input logic [`VT_SW_W-1:0] code);
		logic saw_origin;
		sw         = code;
		saw_origin = 1'b0;
		repeat (SETTLE) begin
			@(negedge pclk);
			if (pos.hcount == 0 && pos.vcount == 0)
				saw_origin = 1'b1;
		end
		check_true(saw_origin,
		           {test_name, ": raster did not restart after the switch change"});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		RSTBTN = 1'b1;
		sw     = 4'b0000;                  // VGA
		repeat (2) begin
			@(negedge pclk);
			check_true(video_out.de == 1'b0, "de active while reset is held");
		end
		RSTBTN = 1'b0;
		check_true(video_out.de == 1'b0, "de active at reset release");
		cur_code  = 4'b0000;
		test_name = "vga_frame";
		measure_frame();
		compare_now();
		test_name = "vga_line";
		measure_line();
		compare_now();
		for (int i = 0; i < N_TESTS; i++) begin
			test_name = test_names[i];
			cur_code  = test_codes[i];
			change_format(test_codes[i]);
			measure_line();
			compare_now();
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin : watchdog
		longint cycles;
		longint cycle_limit;
		cycles      = 0;
		cycle_limit = run_limit();
		while (cycles < cycle_limit) begin
			@(posedge pclk);
			cycles++;
		end
		errors++;
		$display("timeout after %0d cycles, the tests did not complete", cycles);
		$display("checks %0d errors %0d", checks, errors);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/video_timing_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_defs.svh"

module video_timing_top (
	input  logic                    pclk,
	input  logic                    RSTBTN,
	input  logic [`VT_SW_W-1:0]     sw,        // Format switches
	output raster_pkg::video_sync_t video_out,
	output raster_pkg::raster_pos_t pos        // Two clocks ahead of video_out
);
	import video_format_pkg::*;
	import raster_pkg::*;

	fmt_code_t     fmt;
	logic          restart;
	logic          restart_q;
	timing_set_t   timing;
	raster_flags_t flags;

	////////////////////////////////////////////////////////////////////////////
	// Switch to format code
	////////////////////////////////////////////////////////////////////////////

	format_select u_format_select (
		.pclk   (pclk),
		.RSTBTN (RSTBTN),
		.sw     (sw),
		.fmt    (fmt),
		.restart(restart)
	);

	timing_table u_timing_table (
		.pclk     (pclk),
		.RSTBTN   (RSTBTN),
		.fmt      (fmt),
		.restart  (restart),
		.timing   (timing),
		.restart_q(restart_q)
	);

	////////////////////////////////////////////////////////////////////////////
	// Raster and output alignment
	////////////////////////////////////////////////////////////////////////////

	raster_counter u_raster_counter (
		.pclk     (pclk),
		.RSTBTN   (RSTBTN),
		.timing   (timing),
		.restart_q(restart_q),
		.pos      (pos),
		.flags    (flags)
	);

	sync_align u_sync_align (
		.pclk     (pclk),
		.RSTBTN   (RSTBTN),
		.flags    (flags),
		.neg_sync (timing.neg_sync),
		.video_out(video_out)
	);

endmodule

`default_nettype wire

// ==== src/sync_align.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_align (
	input  logic                      pclk,
	input  logic                      RSTBTN,
	input  raster_pkg::raster_flags_t flags,
	input  logic                      neg_sync,  // From the format table
	output raster_pkg::video_sync_t   video_out
);
	import raster_pkg::*;

	video_sync_t sync_d;  // Polarity applied
	video_sync_t sync_q1; // First alignment stage

	always_comb begin
		sync_d.hsync = flags.hsync ^ neg_sync;
		sync_d.vsync = flags.vsync ^ neg_sync;
		sync_d.de    = !flags.hblnk && !flags.vblnk; // Live in both axes
	end

	////////////////////////////////////////////////////////////////////////////
	// Two-stage delay line
	////////////////////////////////////////////////////////////////////////////

	// All three take the same path so they stay aligned
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			sync_q1   <= '0;
			video_out <= '0;
		end else begin
			sync_q1   <= sync_d;
			video_out <= sync_q1;
		end
	end

endmodule

`default_nettype wire

// ==== src/raster_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module raster_counter (
	input  logic                          pclk,
	input  logic                          RSTBTN,
	input  video_format_pkg::timing_set_t timing,
	input  logic                          restart_q, // Back to the origin
	output raster_pkg::raster_pos_t       pos,
	output raster_pkg::raster_flags_t     flags      // Same point as pos
);
	import video_format_pkg::*;
	import raster_pkg::*;

	raster_cnt_t   h_nxt;
	raster_cnt_t   v_nxt;
	logic          h_wrap;    // Last clock of the line
	logic          v_wrap;    // Last line of the frame
	raster_flags_t flags_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////

	// >= so a shorter new format wraps at once
	assign h_wrap = (pos.hcount >= timing.heblnk);
	assign v_wrap = (pos.vcount >= timing.veblnk);

	always_comb begin
		if (restart_q) begin
			h_nxt = '0;
			v_nxt = '0;
		end else if (h_wrap) begin
			h_nxt = '0;
			v_nxt = v_wrap ? raster_cnt_t'(0) : pos.vcount + raster_cnt_t'(1);
		end else begin
			h_nxt = pos.hcount + raster_cnt_t'(1);
			v_nxt = pos.vcount;
		end
	end

	// Flags computed on the next point so they register with it
	always_comb begin
		flags_nxt.hblnk = (h_nxt > timing.hsblnk);
		flags_nxt.hsync = (h_nxt > timing.hssync) && (h_nxt <= timing.hesync);
		flags_nxt.vblnk = (v_nxt > timing.vsblnk);
		flags_nxt.vsync = (v_nxt > timing.vssync) && (v_nxt <= timing.vesync);
	end

	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			pos   <= '0;
			flags <= '0;
		end else begin
			pos.hcount <= h_nxt;
			pos.vcount <= v_nxt;
			flags      <= flags_nxt;
		end
	end

	// Outside a format change the line stays inside its table
	a_h_bound : assert property (@(posedge pclk) disable iff (RSTBTN)
		($stable(timing) && !restart_q) |-> (pos.hcount <= timing.heblnk))
		else $error("raster_counter: hcount %0d past heblnk %0d",
		            pos.hcount, timing.heblnk);

endmodule

`default_nettype wire

// ==== src/timing_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module timing_table (
	input  logic                          pclk,
	input  logic                          RSTBTN,
	input  video_format_pkg::fmt_code_t   fmt,
	input  logic                          restart,
	output video_format_pkg::timing_set_t timing,
	output logic                          restart_q  // Lines up with the counter load
);
	import video_format_pkg::*;

	// One axis of a format
	typedef struct packed {
		raster_cnt_t live;  // Live pixels or lines
		raster_cnt_t fp;    // Front porch
		raster_cnt_t pw;    // Sync width
		raster_cnt_t bp;    // Back porch
	} axis_t;

	////////////////////////////////////////////////////////////////////////////
	// Format constants
	////////////////////////////////////////////////////////////////////////////

	localparam axis_t VGA_H    = '{11'd640,  11'd16,  11'd96,  11'd48};
	localparam axis_t VGA_V    = '{11'd480,  11'd10,  11'd2,   11'd33}; // 525 lines
	localparam axis_t SVGA_H   = '{11'd800,  11'd40,  11'd128, 11'd88};
	localparam axis_t SVGA_V   = '{11'd600,  11'd1,   11'd4,   11'd23};
	localparam axis_t XGA_H    = '{11'd1024, 11'd24,  11'd136, 11'd160};
	localparam axis_t XGA_V    = '{11'd768,  11'd3,   11'd6,   11'd29};
	localparam axis_t HD720_H  = '{11'd1280, 11'd110, 11'd40,  11'd220};
	localparam axis_t HD720_V  = '{11'd720,  11'd5,   11'd5,   11'd20};
	localparam axis_t SXGA_H   = '{11'd1280, 11'd48,  11'd112, 11'd248};
	localparam axis_t SXGA_V   = '{11'd1024, 11'd1,   11'd3,   11'd38};
	localparam axis_t CAMERA_H = '{11'd1280, 11'd110, 11'd39,  11'd220}; // Short hsync
	localparam axis_t CAMERA_V = '{11'd720,  11'd4,   11'd4,   11'd22};

	timing_set_t timing_d;

	// Running sums from the live count
	function automatic timing_set_t build_set(input axis_t h, input axis_t v,
	                                          input logic neg);
		timing_set_t t;
		t.hsblnk   = h.live - 11'd1;
		t.hssync   = t.hsblnk + h.fp;
		t.hesync   = t.hssync + h.pw;
		t.heblnk   = t.hesync + h.bp;
		t.vsblnk   = v.live - 11'd1;
		t.vssync   = t.vsblnk + v.fp;
		t.vesync   = t.vssync + v.pw;
		t.veblnk   = t.vesync + v.bp;
		t.neg_sync = neg;
		return t;
	endfunction

	always_comb begin
		case (fmt)
			FMT_VGA:    timing_d = build_set(VGA_H, VGA_V, 1'b1);       // Negative
			FMT_SVGA:   timing_d = build_set(SVGA_H, SVGA_V, 1'b0);
			FMT_XGA:    timing_d = build_set(XGA_H, XGA_V, 1'b1);       // Negative
			FMT_SXGA:   timing_d = build_set(SXGA_H, SXGA_V, 1'b0);
			FMT_CAMERA: timing_d = build_set(CAMERA_H, CAMERA_V, 1'b0);
			default:    timing_d = build_set(HD720_H, HD720_V, 1'b0);   // 720p
		endcase
	end

	// Reloaded every clock from fmt
	always_ff @(posedge pclk) begin
		timing <= timing_d;
	end

	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			restart_q <= 1'b0;
		end else begin
			restart_q <= restart;
		end
	end

	// Horizontal landmarks strictly in order for every format
	a_h_order : assert property (@(posedge pclk) disable iff (RSTBTN)
		(timing.hsblnk < timing.hssync) && (timing.hssync < timing.hesync) &&
		(timing.hesync < timing.heblnk))
		else $error("timing_table: horizontal counts out of order");

endmodule

`default_nettype wire

// ==== src/format_select.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "video_defs.svh"

module format_select (
	input  logic                        pclk,
	input  logic                        RSTBTN,
	input  logic [`VT_SW_W-1:0]         sw,      // Asynchronous switch bank
	output video_format_pkg::fmt_code_t fmt,
	output logic                        restart  // One clock per format change
);
	import video_format_pkg::*;

	logic [`VT_SYNC_STAGES-1:0][`VT_SW_W-1:0] sw_sync; // [0] may go metastable
	logic [`VT_SW_W-1:0]                      sw_code; // Safe to decode
	fmt_code_t                                fmt_d;
	fmt_code_t                                fmt_prev;

	////////////////////////////////////////////////////////////////////////////
	// Synchronizer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			sw_sync <= '0;
		end else begin
			sw_sync <= {sw_sync[`VT_SYNC_STAGES-2:0], sw}; // Shift in at [0]
		end
	end

	assign sw_code = sw_sync[`VT_SYNC_STAGES-1];

	// Unlisted codes fall back to 720p
	always_comb begin
		case (sw_code)
			FMT_VGA, FMT_SVGA, FMT_HD720, FMT_XGA, FMT_SXGA, FMT_CAMERA:
				fmt_d = fmt_code_t'(sw_code);
			default:
				fmt_d = FMT_HD720;
		endcase
	end

	// Format register and change detect
	always_ff @(posedge pclk) begin
		if (RSTBTN) begin
			fmt      <= FMT_VGA;
			fmt_prev <= FMT_VGA;
			restart  <= 1'b0;
		end else begin
			fmt      <= fmt_d;
			fmt_prev <= fmt;
			restart  <= (fmt != fmt_prev); // One clock behind the new fmt
		end
	end

	// Switch must hold for more than one clock after sync
	a_restart_pulse : assert property (@(posedge pclk) disable iff (RSTBTN)
		restart |=> !restart)
		else $error("format_select: restart held for two cycles");

endmodule

`default_nettype wire

// ==== src/raster_pkg.sv ====
`default_nettype none

package raster_pkg;

	// Current raster point
	typedef struct packed {
		video_format_pkg::raster_cnt_t hcount;
		video_format_pkg::raster_cnt_t vcount;
	} raster_pos_t;

	// Raw flags from the counters
	// All active high, polarity not yet applied
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic hblnk;
		logic vblnk;
	} raster_flags_t;

	// What leaves the chip, at final polarity
	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;    // Live pixel
	} video_sync_t;

endpackage

`default_nettype wire

// ==== src/video_format_pkg.sv ====
`default_nettype none

`include "video_defs.svh"

package video_format_pkg;

	// Any horizontal or vertical raster count
	typedef logic [`VT_CNT_W-1:0] raster_cnt_t;

	// Switch codes as set on the board
	typedef enum logic [`VT_SW_W-1:0] {
		FMT_VGA    = 4'b0000, // 640x480
		FMT_SVGA   = 4'b0001, // 800x600
		FMT_HD720  = 4'b0010, // 1280x720, also the fallback
		FMT_XGA    = 4'b0011, // 1024x768
		FMT_SXGA   = 4'b1000, // 1280x1024
		FMT_CAMERA = 4'b1001  // Camera variant of 720p
	} fmt_code_t;

	////////////////////////////////////////////////////////////////////////////
	// Per-format counts as compared by the raster counter
	////////////////////////////////////////////////////////////////////////////

	// Counts are 0-based positions on the line or in the frame
	typedef struct packed {
		raster_cnt_t hsblnk;   // Last live pixel
		raster_cnt_t hssync;   // End of front porch
		raster_cnt_t hesync;   // Last hsync clock
		raster_cnt_t heblnk;   // Last clock of the line
		raster_cnt_t vsblnk;   // Last live line
		raster_cnt_t vssync;
		raster_cnt_t vesync;
		raster_cnt_t veblnk;   // Last line of the frame
		logic        neg_sync; // Both syncs active low
	} timing_set_t;

endpackage

`default_nettype wire

// ==== src/video_defs.svh ====
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Raster timing widths
////////////////////////////////////////////////////////////////////////////

// Horizontal and vertical counts
// 11 bits covers the longest SXGA line of 1688 clocks
`define VT_CNT_W 11

// Format switch bank on the board
`define VT_SW_W 4

////////////////////////////////////////////////////////////////////////////
// Clock domain crossing
////////////////////////////////////////////////////////////////////////////

// Flops in the switch synchronizer
`define VT_SYNC_STAGES 2

`endif
